// ==== verilog.f ====
+incdir+logic
logic/rv_decode_pkg.sv
logic/imm_gen.sv
logic/rv32i_ctrl.sv
logic/rv32m_ctrl.sv
logic/id_stage.sv
tb/id_stage_props.sv
tb/id_checker.sv
tb/tb_id_stage.sv

// ==== tb/tb_id_stage.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"

module tb_id_stage import rv_decode_pkg::*; ();

	localparam logic [31:0] K_OPC	= 32'h0000007F;	// Opcode only.
	localparam logic [31:0] K_F3	= 32'h0000707F;
	localparam logic [31:0] K_R		= 32'hFE00707F;	// Plus funct7.
	localparam logic [31:0] K_ALL	= 32'hFFFFFFFF;

	logic						clk;
	logic						rst_n;
	logic	[`XLEN-1:0]			inst;
	logic						inst_valid;
	logic						dec_valid;
	logic	[`XLEN-1:0]			imm;
	logic	[`REG_ADDR_W-1:0]	rs1_addr, rs2_addr, rd_addr;
	logic						rs1_access, rs2_access, rd_access, sel_pc, sel_imm;
	logic						jump_ena, jump_ind, jump_alw, illegal_inst;
	wb_src_e					wb_src;
	alu_op_e					alu_op;
	mem_op_e					mem_op;
	mul_op_e					mul_op;
	div_op_e					div_op;
	logic						exp_row, exp_valid;
	logic	[63:0]				exp_name;
	logic	[`XLEN-1:0]			exp_imm;
	logic	[14:0]				exp_regs;
	logic	[8:0]				exp_flags;
	logic	[15:0]				exp_ops;
	int							done_cnt, err_cnt;
	logic	[63:0]				name_q [$];
	logic	[31:0]				tmpl_q [$];
	logic	[31:0]				keep_q [$];
	imm_fmt_e					fmt_q [$];
	logic	[8:0]				flags_q [$];
	logic	[15:0]				ops_q [$];
	logic						valid_q [$];
	logic	[63:0]				m_names [8] = '{"MUL", "MULH", "MULHSU", "MULHU",
		"DIV", "DIVU", "REM", "REMU"};

	id_stage i_id_stage (.*);

	id_checker i_id_checker (
		.regs	({rs1_addr, rs2_addr, rd_addr}),
		.flags	({rs1_access, rs2_access, rd_access, sel_pc, sel_imm,
			jump_ena, jump_ind, jump_alw, illegal_inst}),
		.ops	({wb_src, alu_op, mem_op, mul_op, div_op}),
		.*
	);

	bind id_stage id_stage_props i_id_stage_props (.*);

	always #50 clk = ~clk;

	// Immediate layouts of the base ISA with the sign in instruction bit 31.
	function automatic logic [31:0] expect_imm(input imm_fmt_e fmt, input logic [31:0] w);
		case (fmt)
		IMM_I:		return $signed(w[31:20]);
		IMM_S:		return $signed({w[31:25], w[11:7]});
		IMM_B:		return $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
		IMM_U:		return {w[31:12], 12'h000};
		IMM_J:		return $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
		default:	return '0;
		endcase
	endfunction

	task automatic add_row(input logic valid, input logic [63:0] name, input logic [31:0] tmpl,
		input logic [31:0] keep, input imm_fmt_e fmt, input logic [8:0] flags,
		input wb_src_e wb, input alu_op_e alu, input mem_op_e mem, input logic [5:0] md);
		valid_q.push_back(valid);
		name_q.push_back(name);
		tmpl_q.push_back(tmpl);
		keep_q.push_back(keep);
		fmt_q.push_back(fmt);
		flags_q.push_back(flags);
		ops_q.push_back({wb, alu, mem, md});
	endtask

	initial begin
		int				wait_cycles;
		logic	[31:0]	word;
		clk = 1'b0;
		rst_n = 1'b0;
		inst = '0;
		inst_valid = 1'b0;
		exp_row = 1'b0;
		exp_valid = 1'b0;
		exp_name = '0;
		exp_imm = '0;
		exp_regs = '0;
		exp_flags = '0;
		exp_ops = '0;
		void'($urandom(76845));
		// Flag order rs1 rs2 rd then pc imm then jump ena ind alw then illegal.
		add_row(1, "ADDI", 32'h13, K_F3, IMM_I, 9'b101_01_000_0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(0, "IDLE", 32'h6F, K_OPC, IMM_NONE, 9'b0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(1, "SRAI", 32'h40005013, K_R, IMM_I, 9'b101_01_000_0, WB_ALU, ALU_SRA,
			MEM_NONE, 0);
		add_row(1, "JALR", 32'h67, K_F3, IMM_I, 9'b101_10_111_0, WB_ALU, ALU_INC, MEM_NONE, 0);
		add_row(1, "LW", 32'h2003, K_F3, IMM_I, 9'b101_01_000_0, WB_MEM, ALU_ADD, MEM_LW, 0);
		add_row(1, "SH", 32'h1023, K_F3, IMM_S, 9'b110_01_000_0, WB_MEM, ALU_ADD, MEM_SH, 0);
		add_row(1, "BGEU", 32'h7063, K_F3, IMM_B, 9'b110_00_100_0, WB_ALU, ALU_SGEU, MEM_NONE, 0);
		add_row(1, "JAL", 32'h6F, K_OPC, IMM_J, 9'b001_10_101_0, WB_ALU, ALU_INC, MEM_NONE, 0);
		add_row(1, "LUI", 32'h37, K_OPC, IMM_U, 9'b001_01_000_0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(1, "AUIPC", 32'h17, K_OPC, IMM_U, 9'b001_11_000_0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(1, "SUB", 32'h40000033, K_R, IMM_NONE, 9'b111_00_000_0, WB_ALU, ALU_SUB,
			MEM_NONE, 0);
		add_row(0, "IDLE", 32'h2003, K_F3, IMM_NONE, 9'b0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(0, "IDLE", 32'h02000033, K_R, IMM_NONE, 9'b0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(1, "SLTU", 32'h3033, K_R, IMM_NONE, 9'b111_00_000_0, WB_ALU, ALU_SLTU, MEM_NONE, 0);
		for (int f = 0; f < 8; f++)
			add_row(1, m_names[f], 32'h02000033 | (f << 12), K_R, IMM_NONE, 9'b111_00_000_0,
				(f < 4) ? WB_MUL : WB_DIV, ALU_ADD, MEM_NONE,
				(f < 4) ? 6'((f + 1) << 3) : 6'(f - 3));
		add_row(1, "FENCE", 32'h0F, K_ALL, IMM_NONE, 9'b0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(1, "ECALL", 32'h73, K_ALL, IMM_NONE, 9'b0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(1, "EBREAK", 32'h00100073, K_ALL, IMM_NONE, 9'b0, WB_ALU, ALU_ADD, MEM_NONE, 0);
		add_row(1, "ILL_OPC", 32'h7F, K_ALL, IMM_NONE, 9'b000_00_000_1, WB_ALU, ALU_ADD,
			MEM_NONE, 0);
		add_row(1, "BAD_F7", 32'h04000033, K_R, IMM_NONE, 9'b000_00_000_1, WB_ALU, ALU_ADD,
			MEM_NONE, 0);

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		for (int r = 0; r < name_q.size(); r++) begin
			word = ($urandom & ~keep_q[r]) | tmpl_q[r];	// Random regs and immediate.
			@(posedge clk);
			inst <= word;
			inst_valid <= valid_q[r];
			exp_row <= 1'b1;
			exp_valid <= valid_q[r];
			exp_name <= name_q[r];
			exp_imm <= expect_imm(fmt_q[r], word);
			exp_regs <= {word[19:15], word[24:20], word[11:7]};
			exp_flags <= flags_q[r];
			exp_ops <= ops_q[r];
		end
		@(posedge clk);
		inst_valid <= 1'b0;
		exp_row <= 1'b0;

		wait_cycles = 0;
		while ((done_cnt < name_q.size()) && (wait_cycles < 20)) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (done_cnt != name_q.size())
			$display("Timeout: checker finished %0d of %0d tests", done_cnt, name_q.size());
		$display("Tests: %0d, errors: %0d, assertion failures: %0d", done_cnt, err_cnt,
			i_id_stage.i_id_stage_props.fail_cnt);
		if ((done_cnt == name_q.size()) && (err_cnt == 0) &&
			(i_id_stage.i_id_stage_props.fail_cnt == 0))
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tb/id_checker.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"

module id_checker import rv_decode_pkg::*; (
	input	logic						clk,
	input	logic						dec_valid,
	input	logic	[`XLEN-1:0]			imm,
	input	logic	[3*`REG_ADDR_W-1:0]	regs,		// rs1, rs2, rd.
	input	logic	[8:0]				flags,
	input	logic	[15:0]				ops,		// wb, alu, mem, mul, div.
	input	logic						exp_row,
	input	logic						exp_valid,
	input	logic	[63:0]				exp_name,
	input	logic	[`XLEN-1:0]			exp_imm,
	input	logic	[3*`REG_ADDR_W-1:0]	exp_regs,
	input	logic	[8:0]				exp_flags,
	input	logic	[15:0]				exp_ops,
	output	int							done_cnt,
	output	int							err_cnt
);

	logic						pend_row = 1'b0;
	logic						pend_valid;
	logic	[63:0]				pend_name;
	logic	[`XLEN-1:0]			pend_imm;
	logic	[3*`REG_ADDR_W-1:0]	pend_regs;
	logic	[8:0]				pend_flags;
	logic	[15:0]				pend_ops;
	bit							row_bad;
	string						flag_names [9] = '{"rs1_access", "rs2_access", "rd_access",
		"sel_pc", "sel_imm", "jump_ena", "jump_ind", "jump_alw", "illegal_inst"};

	initial begin
		done_cnt = 0;
		err_cnt = 0;
	end

	task automatic compare_field(input string sig, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (act_val !== exp_val) begin
			$display("CHECK FAILED %0s %0s: expected %h, got %h", pend_name, sig, exp_val, act_val);
			row_bad = 1'b1;
		end
	endtask

	// Expected values lag one edge like the stage.
	always @(posedge clk) begin
		if (pend_row) begin
			row_bad = 1'b0;
			if (dec_valid !== pend_valid) begin
				row_bad = 1'b1;
				if (pend_valid)
					$display("%0s: decoded result did not arrive one cycle after the input",
						pend_name);
				else
					$display("%0s: dec_valid high after an idle input cycle", pend_name);
			end
			for (int i = 0; i < 9; i++)
				compare_field(flag_names[i], pend_flags[8 - i], flags[8 - i]);
			compare_field("mem_op", pend_ops[9:6], ops[9:6]);
			compare_field("mul_op", pend_ops[5:3], ops[5:3]);
			compare_field("div_op", pend_ops[2:0], ops[2:0]);
			if (pend_valid) begin
				compare_field("imm", pend_imm, imm);
				compare_field("rs1_addr", pend_regs[14:10], regs[14:10]);
				compare_field("rs2_addr", pend_regs[9:5], regs[9:5]);
				compare_field("rd_addr", pend_regs[4:0], regs[4:0]);
				compare_field("wb_src", pend_ops[15:14], ops[15:14]);
				compare_field("alu_op", pend_ops[13:10], ops[13:10]);
			end
			$display("%0s: %0s", pend_name, row_bad ? "fail" : "pass");
			done_cnt <= done_cnt + 1;
			err_cnt <= err_cnt + row_bad;
		end
		pend_row <= exp_row;
		pend_valid <= exp_valid;
		pend_name <= exp_name;
		pend_imm <= exp_imm;
		pend_regs <= exp_regs;
		pend_flags <= exp_flags;
		pend_ops <= exp_ops;
	end

endmodule

// ==== tb/id_stage_props.sv ====
`timescale 1ns/1ns

module id_stage_props import rv_decode_pkg::*; (
	input	logic		clk,
	input	logic		rst_n,
	input	logic		dec_valid,
	input	logic		rs1_access, rs2_access, rd_access,
	input	logic		sel_pc, sel_imm,
	input	logic		jump_ena, jump_ind, jump_alw,
	input	logic		illegal_inst,
	input	mem_op_e	mem_op,
	input	mul_op_e	mul_op,
	input	div_op_e	div_op
);

	int fail_cnt = 0;	// Read by the testbench top.

	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!dec_valid |-> !(rs1_access || rs2_access || rd_access || sel_pc || sel_imm ||
		jump_ena || jump_ind || jump_alw || illegal_inst) &&
		(mem_op == MEM_NONE) && (mul_op == MUL_NONE) && (div_op == DIV_NONE))
		else begin
			$error("control output active while dec_valid is low");
			fail_cnt++;
		end

	a_jump_ena: assert property (@(posedge clk) disable iff (!rst_n)
		(jump_ind || jump_alw) |-> jump_ena)
		else begin
			$error("jump_ind or jump_alw without jump_ena");
			fail_cnt++;
		end

	a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		illegal_inst |-> !(rs1_access || rs2_access || rd_access))
		else begin
			$error("register access flagged on an illegal instruction");
			fail_cnt++;
		end

	a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
		!((mul_op != MUL_NONE) && (div_op != DIV_NONE)))
		else begin
			$error("multiply and divide ops active together");
			fail_cnt++;
		end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"

module id_stage import rv_decode_pkg::*; (
	input	logic						clk,
	input	logic						rst_n,
	input	logic	[`XLEN-1:0]			inst,
	input	logic						inst_valid,
	output	logic						dec_valid,
	output	logic	[`XLEN-1:0]			imm,
	output	logic	[`REG_ADDR_W-1:0]	rs1_addr,
	output	logic	[`REG_ADDR_W-1:0]	rs2_addr,
	output	logic	[`REG_ADDR_W-1:0]	rd_addr,
	output	logic						rs1_access,
	output	logic						rs2_access,
	output	logic						rd_access,
	output	logic						sel_pc,
	output	logic						sel_imm,
	output	wb_src_e					wb_src,
	output	alu_op_e					alu_op,
	output	mem_op_e					mem_op,
	output	mul_op_e					mul_op,
	output	div_op_e					div_op,
	output	logic						jump_ena,
	output	logic						jump_ind,
	output	logic						jump_alw,
	output	logic						illegal_inst
);

	imm_fmt_e				imm_fmt;
	logic	[`XLEN-1:0]		imm_c;
	logic					base_rs1_access;
	logic					base_rs2_access;
	logic					base_rd_access;
	logic					base_sel_pc;
	logic					base_sel_imm;
	wb_src_e				base_wb_src;
	alu_op_e				base_alu_op;
	mem_op_e				base_mem_op;
	logic					base_jump_ena;
	logic					base_jump_ind;
	logic					base_jump_alw;
	logic					base_illegal;
	logic					m_hit;
	mul_op_e				mul_op_c;
	div_op_e				div_op_c;
	wb_src_e				wb_src_c;

	imm_gen i_imm_gen (
		.inst		(inst),
		.imm_fmt	(imm_fmt),
		.imm		(imm_c)
	);

	rv32i_ctrl i_rv32i_ctrl (
		.inst			(inst),
		.imm_fmt		(imm_fmt),
		.rs1_access		(base_rs1_access),
		.rs2_access		(base_rs2_access),
		.rd_access		(base_rd_access),
		.sel_pc			(base_sel_pc),
		.sel_imm		(base_sel_imm),
		.wb_src			(base_wb_src),
		.alu_op			(base_alu_op),
		.mem_op			(base_mem_op),
		.jump_ena		(base_jump_ena),
		.jump_ind		(base_jump_ind),
		.jump_alw		(base_jump_alw),
		.base_illegal	(base_illegal)
	);

	rv32m_ctrl i_rv32m_ctrl (
		.inst		(inst),
		.m_hit		(m_hit),
		.mul_op		(mul_op_c),
		.div_op		(div_op_c)
	);

	// M ops pick their own result unit.
	assign wb_src_c = !m_hit ? base_wb_src : ((mul_op_c != MUL_NONE) ? WB_MUL : WB_DIV);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid		<= 1'b0;
			rs1_access		<= 1'b0;
			rs2_access		<= 1'b0;
			rd_access		<= 1'b0;
			sel_pc			<= 1'b0;
			sel_imm			<= 1'b0;
			wb_src			<= WB_ALU;
			alu_op			<= ALU_ADD;
			mem_op			<= MEM_NONE;
			mul_op			<= MUL_NONE;
			div_op			<= DIV_NONE;
			jump_ena		<= 1'b0;
			jump_ind		<= 1'b0;
			jump_alw		<= 1'b0;
			illegal_inst	<= 1'b0;
		end else begin
			// Idle cycles register inactive controls.
			dec_valid		<= inst_valid;
			rs1_access		<= inst_valid && (base_rs1_access || m_hit);
			rs2_access		<= inst_valid && (base_rs2_access || m_hit);
			rd_access		<= inst_valid && (base_rd_access || m_hit);
			sel_pc			<= inst_valid && base_sel_pc;
			sel_imm			<= inst_valid && base_sel_imm;
			wb_src			<= inst_valid ? wb_src_c : WB_ALU;
			alu_op			<= inst_valid ? base_alu_op : ALU_ADD;
			mem_op			<= inst_valid ? base_mem_op : MEM_NONE;
			mul_op			<= inst_valid ? mul_op_c : MUL_NONE;
			div_op			<= inst_valid ? div_op_c : DIV_NONE;
			jump_ena		<= inst_valid && base_jump_ena;
			jump_ind		<= inst_valid && base_jump_ind;
			jump_alw		<= inst_valid && base_jump_alw;
			illegal_inst	<= inst_valid && base_illegal && !m_hit;
		end
	end

	// Register fields and immediate.
	always_ff @(posedge clk) begin
		imm			<= imm_c;
		rs1_addr	<= inst[19:15];
		rs2_addr	<= inst[24:20];
		rd_addr		<= inst[11:7];
	end

endmodule

// ==== logic/rv32m_ctrl.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"

module rv32m_ctrl import rv_decode_pkg::*; (
	input	logic	[`XLEN-1:0]	inst,
	output	logic				m_hit,
	output	mul_op_e			mul_op,
	output	div_op_e			div_op
);

	opcode_e		opcode;
	logic	[2:0]	funct3;
	logic	[6:0]	funct7;

	assign opcode	= opcode_e'(inst[6:0]);
	assign funct3	= inst[14:12];
	assign funct7	= inst[31:25];
	assign m_hit	= (opcode == OPC_OP) && (funct7 == `FUNCT7_MULDIV);

	// funct3 bit 2 splits multiplier and divider.
	always_comb begin
		mul_op = MUL_NONE;
		div_op = DIV_NONE;
		if (m_hit) begin
			case (funct3)
			3'd0: begin
				mul_op = MUL_MULL;
			end
			3'd1: begin
				mul_op = MUL_MULH;
			end
			3'd2: begin
				mul_op = MUL_MULHSU;
			end
			3'd3: begin
				mul_op = MUL_MULHU;
			end
			3'd4: begin
				div_op = DIV_DIV;
			end
			3'd5: begin
				div_op = DIV_DIVU;
			end
			3'd6: begin
				div_op = DIV_REM;
			end
			default: begin
				div_op = DIV_REMU;
			end
			endcase
		end
	end

endmodule

// ==== logic/rv32i_ctrl.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"

module rv32i_ctrl import rv_decode_pkg::*; (
	input	logic	[`XLEN-1:0]	inst,
	output	imm_fmt_e			imm_fmt,
	output	logic				rs1_access,
	output	logic				rs2_access,
	output	logic				rd_access,
	output	logic				sel_pc,
	output	logic				sel_imm,
	output	wb_src_e			wb_src,
	output	alu_op_e			alu_op,
	output	mem_op_e			mem_op,
	output	logic				jump_ena,
	output	logic				jump_ind,
	output	logic				jump_alw,
	output	logic				base_illegal
);

	opcode_e			opcode;
	logic	[2:0]		funct3;
	logic	[6:0]		funct7;
	logic	[11:0]		funct12;
	logic				funct7_alt;
	logic				sys_regs_zero;

	assign opcode			= opcode_e'(inst[6:0]);
	assign funct3			= inst[14:12];
	assign funct7			= inst[31:25];
	assign funct12			= inst[31:20];
	assign funct7_alt		= (funct7 == `FUNCT7_ALT);
	assign sys_regs_zero	= (inst[19:15] == '0) && (inst[11:7] == '0);

	always_comb begin
		imm_fmt			= IMM_NONE;
		rs1_access		= 1'b0;
		rs2_access		= 1'b0;
		rd_access		= 1'b0;
		sel_pc			= 1'b0;
		sel_imm			= 1'b0;
		wb_src			= WB_ALU;
		alu_op			= ALU_ADD;
		mem_op			= MEM_NONE;
		jump_ena		= 1'b0;
		jump_ind		= 1'b0;
		jump_alw		= 1'b0;
		base_illegal	= 1'b0;

		case (opcode)
		OPC_LUI: begin
			imm_fmt		= IMM_U;
			rd_access	= 1'b1;
			sel_imm		= 1'b1;
		end
		OPC_AUIPC: begin
			imm_fmt		= IMM_U;
			rd_access	= 1'b1;
			sel_pc		= 1'b1;
			sel_imm		= 1'b1;
		end
		OPC_JAL: begin
			imm_fmt		= IMM_J;
			rd_access	= 1'b1;
			sel_pc		= 1'b1;
			alu_op		= ALU_INC;	// Link value.
			jump_ena	= 1'b1;
			jump_alw	= 1'b1;
		end
		OPC_JALR: begin
			imm_fmt			= IMM_I;
			rs1_access		= 1'b1;
			rd_access		= 1'b1;
			sel_pc			= 1'b1;
			alu_op			= ALU_INC;
			jump_ena		= 1'b1;
			jump_ind		= 1'b1;
			jump_alw		= 1'b1;
			base_illegal	= (funct3 != 3'b000);
		end
		OPC_BRANCH: begin
			imm_fmt		= IMM_B;
			rs1_access	= 1'b1;
			rs2_access	= 1'b1;
			jump_ena	= 1'b1;	// Taken only if the compare holds.
			case (funct3)
			3'b000:		alu_op = ALU_SEQ;
			3'b001:		alu_op = ALU_SNE;
			3'b100:		alu_op = ALU_SLT;
			3'b101:		alu_op = ALU_SGE;
			3'b110:		alu_op = ALU_SLTU;
			3'b111:		alu_op = ALU_SGEU;
			default:	base_illegal = 1'b1;
			endcase
		end
		OPC_LOAD: begin
			imm_fmt		= IMM_I;
			rs1_access	= 1'b1;
			rd_access	= 1'b1;
			sel_imm		= 1'b1;
			wb_src		= WB_MEM;
			case (funct3)
			3'b000:		mem_op = MEM_LB;
			3'b001:		mem_op = MEM_LH;
			3'b010:		mem_op = MEM_LW;
			3'b100:		mem_op = MEM_LBU;
			3'b101:		mem_op = MEM_LHU;
			default:	base_illegal = 1'b1;
			endcase
		end
		OPC_STORE: begin
			imm_fmt		= IMM_S;
			rs1_access	= 1'b1;
			rs2_access	= 1'b1;
			sel_imm		= 1'b1;
			wb_src		= WB_MEM;
			case (funct3)
			3'b000:		mem_op = MEM_SB;
			3'b001:		mem_op = MEM_SH;
			3'b010:		mem_op = MEM_SW;
			default:	base_illegal = 1'b1;
			endcase
		end
		OPC_OP_IMM: begin
			imm_fmt		= IMM_I;
			rs1_access	= 1'b1;
			rd_access	= 1'b1;
			sel_imm		= 1'b1;
			case (funct3)
			3'b000:		alu_op = ALU_ADD;
			3'b010:		alu_op = ALU_SLT;
			3'b011:		alu_op = ALU_SLTU;
			3'b100:		alu_op = ALU_XOR;
			3'b110:		alu_op = ALU_OR;
			3'b111:		alu_op = ALU_AND;
			3'b001: begin
				alu_op			= ALU_SLL;
				base_illegal	= (funct7 != `FUNCT7_BASE);
			end
			default: begin
				alu_op			= funct7_alt ? ALU_SRA : ALU_SRL;
				base_illegal	= (funct7 != `FUNCT7_BASE) && !funct7_alt;
			end
			endcase
		end
		OPC_OP: begin
			rs1_access	= 1'b1;
			rs2_access	= 1'b1;
			rd_access	= 1'b1;
			case (funct3)
			3'b000:		alu_op = funct7_alt ? ALU_SUB : ALU_ADD;
			3'b001:		alu_op = ALU_SLL;
			3'b010:		alu_op = ALU_SLT;
			3'b011:		alu_op = ALU_SLTU;
			3'b100:		alu_op = ALU_XOR;
			3'b101:		alu_op = funct7_alt ? ALU_SRA : ALU_SRL;
			3'b110:		alu_op = ALU_OR;
			default:	alu_op = ALU_AND;
			endcase
			// M encodings land here too.
			if (funct7_alt)
				base_illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
			else
				base_illegal = (funct7 != `FUNCT7_BASE);
		end
		OPC_MISC_MEM: begin
			base_illegal = (funct3 != 3'b000);	// FENCE only.
		end
		OPC_SYSTEM: begin
			base_illegal = !((funct3 == 3'b000) && sys_regs_zero &&
				((funct12 == `SYSTEM_ECALL) || (funct12 == `SYSTEM_EBREAK)));
		end
		default: begin
			base_illegal = 1'b1;
		end
		endcase

		if (base_illegal) begin
			imm_fmt		= IMM_NONE;
			rs1_access	= 1'b0;
			rs2_access	= 1'b0;
			rd_access	= 1'b0;
			sel_pc		= 1'b0;
			sel_imm		= 1'b0;
			wb_src		= WB_ALU;
			alu_op		= ALU_ADD;
			mem_op		= MEM_NONE;
			jump_ena	= 1'b0;
			jump_ind	= 1'b0;
			jump_alw	= 1'b0;
		end
	end

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"

module imm_gen import rv_decode_pkg::*; (
	input	logic	[`XLEN-1:0]	inst,
	input	imm_fmt_e			imm_fmt,
	output	logic	[`XLEN-1:0]	imm
);

	logic	[`XLEN-1:0]	imm_i;
	logic	[`XLEN-1:0]	imm_s;
	logic	[`XLEN-1:0]	imm_b;
	logic	[`XLEN-1:0]	imm_u;
	logic	[`XLEN-1:0]	imm_j;

	// All formats sign extend from bit 31.
	assign imm_i = {{(`XLEN-11){inst[31]}}, inst[30:20]};
	assign imm_s = {{(`XLEN-11){inst[31]}}, inst[30:25], inst[11:7]};
	assign imm_b = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'h000};
	assign imm_j = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (imm_fmt)
		IMM_I: begin
			imm = imm_i;
		end
		IMM_S: begin
			imm = imm_s;
		end
		IMM_B: begin
			imm = imm_b;
		end
		IMM_U: begin
			imm = imm_u;
		end
		IMM_J: begin
			imm = imm_j;
		end
		default: begin
			imm = '0;	// No immediate.
		end
		endcase
	end

endmodule

// ==== logic/rv_decode_pkg.sv ====
package rv_decode_pkg;

	// Major opcodes, bits 6:0 of the instruction.
	typedef enum logic [6:0] {
		OPC_LOAD		= 7'b0000011,
		OPC_MISC_MEM	= 7'b0001111,
		OPC_OP_IMM		= 7'b0010011,
		OPC_AUIPC		= 7'b0010111,
		OPC_STORE		= 7'b0100011,
		OPC_OP			= 7'b0110011,
		OPC_LUI			= 7'b0110111,
		OPC_BRANCH		= 7'b1100011,
		OPC_JALR		= 7'b1100111,
		OPC_JAL			= 7'b1101111,
		OPC_SYSTEM		= 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		IMM_NONE,
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J
	} imm_fmt_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_INC,		// Return address of PC plus four.
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_SGE,
		ALU_SGEU,
		ALU_SEQ,
		ALU_SNE,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LH,
		MEM_LW,
		MEM_LBU,
		MEM_LHU,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_e;

	typedef enum logic [2:0] {
		MUL_NONE,
		MUL_MULL,
		MUL_MULH,
		MUL_MULHSU,
		MUL_MULHU
	} mul_op_e;

	typedef enum logic [2:0] {
		DIV_NONE,
		DIV_DIV,
		DIV_DIVU,
		DIV_REM,
		DIV_REMU
	} div_op_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_MUL,
		WB_DIV
	} wb_src_e;

endpackage

// ==== logic/rv_decode_settings.svh ====
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Instruction and immediate width.
`define XLEN			32

// Width of one register address field.
`define REG_ADDR_W		5

// funct7 encodings on the OP major opcode.
`define FUNCT7_BASE		7'b0000000
`define FUNCT7_ALT		7'b0100000
`define FUNCT7_MULDIV	7'b0000001

// Immediate field of the SYSTEM calls.
`define SYSTEM_ECALL	12'h000
`define SYSTEM_EBREAK	12'h001

`endif
